// ==== include/kv_register_settings.svh ====
// ==============================
// kv register block settings
// bus widths, register map and the
// identification constant
// ==============================

`ifndef KV_SETTINGS_SVH
`define KV_SETTINGS_SVH

// word address and data widths of the host port and the internal bus
`define KV_ADR_BITS   8
`define KV_DAT_BITS   32

// word addresses of the registers
`define KV_REG_ID     8'h00
`define KV_REG_PMOD   8'h01
`define KV_REG_FAN    8'h02
`define KV_REG_PERIOD 8'h03
`define KV_REG_BLINK  8'h04

`define KV_ID_VALUE   32'h4B560260

`endif

// ==== verilog/reg_bus_pkg.sv ====
// ==============================
// register bus types
// access kinds and register names on
// the internal register bus
// ==============================

`default_nettype none

package reg_bus_pkg;

    // kind of access carried by one request
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // decoded register index, REG_NONE marks an unmapped address
    typedef enum logic [2:0] {
        REG_ID     = 3'd0,
        REG_PMOD   = 3'd1,
        REG_FAN    = 3'd2,
        REG_PERIOD = 3'd3,
        REG_BLINK  = 3'd4,
        REG_NONE   = 3'd7
    } reg_idx_e;

endpackage

`default_nettype wire

// ==== verilog/periph_pkg.sv ====
// ==============================
// peripheral types
// blink sequencer states and fan modes
// ==============================

`default_nettype none

package periph_pkg;

    typedef enum logic [1:0] {
        BLINK_IDLE  = 2'd0,
        BLINK_COUNT = 2'd1,
        BLINK_WRITE = 2'd2,
        BLINK_WAIT  = 2'd3
    } blink_state_e;

    // the fan has no speed control, only on and off
    typedef enum logic {
        FAN_OFF = 1'b0,
        FAN_ON  = 1'b1
    } fan_mode_e;

endpackage

`default_nettype wire

// ==== verilog/reg_bus_if.sv ====
// ==============================
// internal register bus link
// one master to one slave, req held
// until a single cycle ack
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "kv_register_settings.svh"

interface reg_bus_if
    import reg_bus_pkg::*;
    ();

    logic                       req;
    bus_op_e                    op;
    logic [`KV_ADR_BITS-1:0]    addr;
    logic [`KV_DAT_BITS-1:0]    wdata;
    logic [`KV_DAT_BITS-1:0]    rdata;
    logic                       ack;

    modport master (
        output req,
        output op,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

// ==== verilog/wb_reg_port.sv ====
// ==============================
// wishbone classic slave port
// turns one host strobe into one access
// on the internal register bus
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "kv_register_settings.svh"

module wb_reg_port
    import reg_bus_pkg::*;
    (
        input  var logic                        clk,
        input  var logic                        rst_i,
        input  var logic [`KV_ADR_BITS-1:0]     wb_adr_i,
        input  var logic [`KV_DAT_BITS-1:0]     wb_dat_i,
        input  var logic [`KV_DAT_BITS/8-1:0]   wb_sel_i,
        input  var logic                        wb_we_i,
        input  var logic                        wb_stb_i,
        output var logic [`KV_DAT_BITS-1:0]     wb_dat_o,
        output var logic                        wb_ack_o,
        reg_bus_if.master                       bus
    );

    logic take;

    // the host still holds stb while wb_ack_o is high, so that cycle is skipped
    assign take = wb_stb_i && !bus.req && !wb_ack_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.req  <= 1'b0;
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;
            if (take) begin
                bus.req <= 1'b1;
            end else if (bus.ack) begin
                bus.req  <= 1'b0;
                wb_ack_o <= 1'b1;
            end
        end
    end

    // only full word writes are honored, a partial one becomes a harmless read
    always_ff @(posedge clk) begin
        if (take) begin
            bus.op    <= (wb_we_i && (&wb_sel_i)) ? OP_WRITE : OP_READ;
            bus.addr  <= wb_adr_i;
            bus.wdata <= wb_dat_i;
        end
        if (bus.ack) begin
            wb_dat_o <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/blink_sequencer.sv ====
// ==============================
// blink sequencer
// bus master that rotates a one-hot
// pattern into the pmod register
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "kv_register_settings.svh"

module blink_sequencer
    import reg_bus_pkg::*;
    import periph_pkg::*;
    (
        input  var logic                        clk,
        input  var logic                        rst_i,
        input  var logic                        blink_en_i,
        input  var logic [`KV_DAT_BITS-1:0]     period_i,
        reg_bus_if.master                       bus
    );

    blink_state_e               state;
    logic [`KV_DAT_BITS-1:0]    count;
    logic [7:0]                 pattern;

    // every access is the same write, only the data changes
    assign bus.op    = OP_WRITE;
    assign bus.addr  = `KV_REG_PMOD;
    assign bus.wdata = {{(`KV_DAT_BITS-8){1'b0}}, pattern};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= BLINK_IDLE;
            count   <= '0;
            pattern <= 8'h01;
            bus.req <= 1'b0;
        end else begin
            case (state)
                BLINK_IDLE: begin
                    if (blink_en_i) begin
                        count <= period_i;
                        state <= BLINK_COUNT;
                    end
                end
                // stays here for period+1 cycles before the write
                BLINK_COUNT: begin
                    if (!blink_en_i) begin
                        state <= BLINK_IDLE;
                    end else if (count == '0) begin
                        bus.req <= 1'b1;
                        state   <= BLINK_WRITE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                // an access in flight is always finished, even if blinking stops
                BLINK_WRITE: begin
                    if (bus.ack) begin
                        bus.req <= 1'b0;
                        pattern <= {pattern[6:0], pattern[7]};
                        state   <= BLINK_WAIT;
                    end
                end
                BLINK_WAIT: begin
                    count <= period_i;
                    state <= blink_en_i ? BLINK_COUNT : BLINK_IDLE;
                end
                default: begin
                    state <= BLINK_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reg_bus_arbiter.sv ====
// ==============================
// register bus arbiter
// two masters onto the register file,
// host first when both ask at once
// ==============================

`timescale 1ns/1ps
`default_nettype none

module reg_bus_arbiter (
        input  var logic    clk,
        input  var logic    rst_i,
        reg_bus_if.slave    host,
        reg_bus_if.slave    seq,
        reg_bus_if.master   file
    );

    logic busy;
    logic owner_seq;

    // the owner is chosen one cycle before its request reaches the file
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy      <= 1'b0;
            owner_seq <= 1'b0;
        end else if (!busy) begin
            if (host.req) begin
                busy      <= 1'b1;
                owner_seq <= 1'b0;
            end else if (seq.req) begin
                busy      <= 1'b1;
                owner_seq <= 1'b1;
            end
        end else if (file.ack) begin
            busy <= 1'b0;
        end
    end

    assign file.req   = busy && (owner_seq ? seq.req : host.req);
    assign file.op    = owner_seq ? seq.op    : host.op;
    assign file.addr  = owner_seq ? seq.addr  : host.addr;
    assign file.wdata = owner_seq ? seq.wdata : host.wdata;

    // a waiting master sees neither ack nor data until it owns the bus
    assign host.ack   = file.ack && !owner_seq;
    assign host.rdata = owner_seq ? '0 : file.rdata;
    assign seq.ack    = file.ack && owner_seq;
    assign seq.rdata  = owner_seq ? file.rdata : '0;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// ==============================
// register file
// id, pmod, fan, blink period and
// blink enable behind the internal bus
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "kv_register_settings.svh"

module reg_file
    import reg_bus_pkg::*;
    import periph_pkg::*;
    (
        input  var logic                        clk,
        input  var logic                        rst_i,
        reg_bus_if.slave                        bus,
        output var logic [7:0]                  pmod_o,
        output var logic                        fan_en_o,
        output var logic                        blink_en_o,
        output var logic [`KV_DAT_BITS-1:0]     period_o
    );

    reg_idx_e                   idx;
    fan_mode_e                  fan_mode;
    logic                       access;
    logic [`KV_DAT_BITS-1:0]    rd_value;

    // req stays high during the ack cycle, which must not count twice
    assign access   = bus.req && !bus.ack;
    assign fan_en_o = (fan_mode == FAN_ON);

    always_comb begin
        case (bus.addr)
            `KV_REG_ID:     idx = REG_ID;
            `KV_REG_PMOD:   idx = REG_PMOD;
            `KV_REG_FAN:    idx = REG_FAN;
            `KV_REG_PERIOD: idx = REG_PERIOD;
            `KV_REG_BLINK:  idx = REG_BLINK;
            default:        idx = REG_NONE;
        endcase
    end

    always_comb begin
        case (idx)
            REG_ID:     rd_value = `KV_ID_VALUE;
            REG_PMOD:   rd_value = {{(`KV_DAT_BITS-8){1'b0}}, pmod_o};
            REG_FAN:    rd_value = {{(`KV_DAT_BITS-1){1'b0}}, fan_en_o};
            REG_PERIOD: rd_value = period_o;
            REG_BLINK:  rd_value = {{(`KV_DAT_BITS-1){1'b0}}, blink_en_o};
            default:    rd_value = '0;
        endcase
    end

    // the id register and unmapped addresses fall through without a write
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.ack    <= 1'b0;
            pmod_o     <= 8'h00;
            fan_mode   <= FAN_OFF;
            period_o   <= '0;
            blink_en_o <= 1'b0;
        end else begin
            bus.ack <= access;
            if (access && (bus.op == OP_WRITE)) begin
                case (idx)
                    REG_PMOD:   pmod_o     <= bus.wdata[7:0];
                    REG_FAN:    fan_mode   <= bus.wdata[0] ? FAN_ON : FAN_OFF;
                    REG_PERIOD: period_o   <= bus.wdata;
                    REG_BLINK:  blink_en_o <= bus.wdata[0];
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.rdata <= rd_value;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/kv_register_top.sv ====
// ==============================
// kv register block top level
// wishbone host port, blink sequencer,
// arbiter and register file
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "kv_register_settings.svh"

module kv_register_top (
        input  var logic                        clk,
        input  var logic                        rst_i,
        input  var logic [`KV_ADR_BITS-1:0]     wb_adr_i,
        input  var logic [`KV_DAT_BITS-1:0]     wb_dat_i,
        input  var logic [`KV_DAT_BITS/8-1:0]   wb_sel_i,
        input  var logic                        wb_we_i,
        input  var logic                        wb_stb_i,
        output var logic [`KV_DAT_BITS-1:0]     wb_dat_o,
        output var logic                        wb_ack_o,
        output var logic [7:0]                  pmod_o,
        output var logic                        fan_en_o
    );

    // blink controls run from the register file back to the sequencer
    logic                       blink_en;
    logic [`KV_DAT_BITS-1:0]    period;

    reg_bus_if host_bus ();
    reg_bus_if seq_bus ();
    reg_bus_if file_bus ();

    wb_reg_port i_wb_reg_port (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_we_i    (wb_we_i),
        .wb_stb_i   (wb_stb_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .bus        (host_bus.master)
    );

    blink_sequencer i_blink_sequencer (
        .clk        (clk),
        .rst_i      (rst_i),
        .blink_en_i (blink_en),
        .period_i   (period),
        .bus        (seq_bus.master)
    );

    reg_bus_arbiter i_reg_bus_arbiter (
        .clk        (clk),
        .rst_i      (rst_i),
        .host       (host_bus.slave),
        .seq        (seq_bus.slave),
        .file       (file_bus.master)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus        (file_bus.slave),
        .pmod_o     (pmod_o),
        .fan_en_o   (fan_en_o),
        .blink_en_o (blink_en),
        .period_o   (period)
    );

endmodule

`default_nettype wire

// ==== tb/tb_kv_register.sv ====
// ==============================
// kv register block testbench
// wishbone host accesses against a shadow
// register model, blinking and contention
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "kv_register_settings.svh"

module tb_kv_register;

    localparam int ACK_TIMEOUT    = 100;
    localparam int CHANGE_TIMEOUT = 400;

    logic                           clk;
    logic                           rst_i;
    logic [`KV_ADR_BITS-1:0]        wb_adr_i;
    logic [`KV_DAT_BITS-1:0]        wb_dat_i;
    logic [`KV_DAT_BITS/8-1:0]      wb_sel_i;
    logic                           wb_we_i;
    logic                           wb_stb_i;
    logic [`KV_DAT_BITS-1:0]        wb_dat_o;
    logic                           wb_ack_o;
    logic [7:0]                     pmod_o;
    logic                           fan_en_o;

    // shadow copy of the writable registers
    logic [7:0]                     shadow_pmod;
    logic                           shadow_fan;
    logic [`KV_DAT_BITS-1:0]        shadow_period;
    logic                           shadow_blink;

    logic [31:0]                    lcg_state;
    logic [7:0]                     pmod_at_ack;
    logic [7:0]                     last_pmod;
    logic [7:0]                     expected_pattern;
    logic [`KV_DAT_BITS-1:0]        data;
    logic [`KV_ADR_BITS-1:0]        unmapped [4];

    kv_register_top i_dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_we_i    (wb_we_i),
        .wb_stb_i   (wb_stb_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .pmod_o     (pmod_o),
        .fan_en_o   (fan_en_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // read value that the register map rules give for an address
    function automatic logic [31:0] expected_read(input logic [`KV_ADR_BITS-1:0] adr);
        case (adr)
            `KV_REG_ID:     return `KV_ID_VALUE;
            `KV_REG_PMOD:   return {24'h0, shadow_pmod};
            `KV_REG_FAN:    return {31'h0, shadow_fan};
            `KV_REG_PERIOD: return shadow_period;
            `KV_REG_BLINK:  return {31'h0, shadow_blink};
            default:        return 32'h0;
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // one wishbone classic transfer, stb is held until wb_ack_o is seen
    task automatic bus_transfer(input logic we, input logic [`KV_ADR_BITS-1:0] adr,
                                input logic [31:0] dat, input logic [3:0] sel,
                                output logic [31:0] rdata);
        int cycles;
        @(posedge clk);
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        wb_we_i  <= we;
        wb_stb_i <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack_o && cycles < ACK_TIMEOUT);
        if (!wb_ack_o) begin
            report_timeout("wb_ack_o");
        end
        rdata       = wb_dat_o;
        pmod_at_ack = pmod_o;
        @(posedge clk);
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        // the strobe was still high in the ack cycle and must not start a second access
        repeat (4) begin
            @(negedge clk);
            check_equal("wb_ack_o", wb_ack_o, 1'b0);
        end
    endtask

    task automatic write_word(input logic [`KV_ADR_BITS-1:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        logic [31:0] unused;
        bus_transfer(1'b1, adr, dat, sel, unused);
        if (sel == 4'hf) begin
            case (adr)
                `KV_REG_PMOD:   shadow_pmod   = dat[7:0];
                `KV_REG_FAN:    shadow_fan    = dat[0];
                `KV_REG_PERIOD: shadow_period = dat;
                `KV_REG_BLINK:  shadow_blink  = dat[0];
                default: begin
                end
            endcase
        end
    endtask

    task automatic read_word(input logic [`KV_ADR_BITS-1:0] adr, output logic [31:0] rdata);
        bus_transfer(1'b0, adr, 32'h0, 4'hf, rdata);
    endtask

    task automatic read_and_check(input logic [`KV_ADR_BITS-1:0] adr);
        logic [31:0] rdata;
        read_word(adr, rdata);
        check_equal("wb_dat_o", rdata, expected_read(adr));
    endtask

    task automatic wait_pmod_change(input logic [7:0] prev);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (pmod_o == prev && cycles < CHANGE_TIMEOUT);
        if (pmod_o == prev) begin
            report_timeout("a change on pmod_o");
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_i         = 1'b1;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_sel_i      = '0;
        wb_we_i       = 1'b0;
        wb_stb_i      = 1'b0;
        shadow_pmod   = 8'h00;
        shadow_fan    = 1'b0;
        shadow_period = '0;
        shadow_blink  = 1'b0;
        lcg_state     = 32'd64;
        unmapped      = '{8'h05, 8'h06, 8'h80, 8'hff};
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);

        // reset values and the read-only identification word
        check_equal("pmod_o", pmod_o, 8'h00);
        check_equal("fan_en_o", fan_en_o, 1'b0);
        read_and_check(`KV_REG_ID);
        lcg_state = lcg_next(lcg_state);
        write_word(`KV_REG_ID, lcg_state, 4'hf);
        read_and_check(`KV_REG_ID);

        // full word writes of random data
        repeat (8) begin
            lcg_state = lcg_next(lcg_state);
            write_word(`KV_REG_PMOD, lcg_state, 4'hf);
            check_equal("pmod_o", pmod_o, shadow_pmod);
            read_and_check(`KV_REG_PMOD);
            lcg_state = lcg_next(lcg_state);
            write_word(`KV_REG_FAN, lcg_state, 4'hf);
            check_equal("fan_en_o", fan_en_o, shadow_fan);
            read_and_check(`KV_REG_FAN);
            lcg_state = lcg_next(lcg_state);
            write_word(`KV_REG_PERIOD, lcg_state, 4'hf);
            read_and_check(`KV_REG_PERIOD);
            lcg_state = lcg_next(lcg_state);
            write_word(`KV_REG_BLINK, lcg_state & 32'hffff_fffe, 4'hf);
            read_and_check(`KV_REG_BLINK);
        end

        // partial byte selects are dropped, unmapped words read as zero
        lcg_state = lcg_next(lcg_state);
        write_word(`KV_REG_PMOD, ~{24'h0, shadow_pmod}, 4'b0111);
        check_equal("pmod_o", pmod_o, shadow_pmod);
        read_and_check(`KV_REG_PMOD);
        write_word(`KV_REG_FAN, {31'h0, ~shadow_fan}, 4'b1110);
        check_equal("fan_en_o", fan_en_o, shadow_fan);
        read_and_check(`KV_REG_FAN);
        foreach (unmapped[i]) begin
            lcg_state = lcg_next(lcg_state);
            write_word(unmapped[i], lcg_state, 4'hf);
            read_and_check(unmapped[i]);
        end

        // running light, one left rotation per change
        write_word(`KV_REG_PMOD, 32'h0, 4'hf);
        write_word(`KV_REG_PERIOD, 32'd12, 4'hf);
        write_word(`KV_REG_BLINK, 32'h1, 4'hf);
        expected_pattern = 8'h01;
        last_pmod        = 8'h00;
        repeat (10) begin
            wait_pmod_change(last_pmod);
            check_equal("pmod_o", pmod_o, expected_pattern);
            read_word(`KV_REG_PMOD, data);
            check_equal("wb_dat_o", data, {24'h0, expected_pattern});
            check_equal("pmod_o", pmod_at_ack, expected_pattern);
            last_pmod        = expected_pattern;
            expected_pattern = {expected_pattern[6:0], expected_pattern[7]};
        end

        // a short period keeps the sequencer on the bus against the host
        write_word(`KV_REG_PERIOD, 32'd1, 4'hf);
        repeat (16) begin
            lcg_state = lcg_next(lcg_state);
            write_word(`KV_REG_FAN, lcg_state, 4'hf);
            check_equal("fan_en_o", fan_en_o, shadow_fan);
            read_and_check(`KV_REG_FAN);
            check_equal("fan_en_o", fan_en_o, shadow_fan);
        end

        // disabling blinking freezes the pattern after any write in flight
        write_word(`KV_REG_BLINK, 32'h0, 4'hf);
        read_and_check(`KV_REG_BLINK);
        repeat (20) @(posedge clk);
        read_word(`KV_REG_PMOD, data);
        check_equal("wb_dat_o", data, {24'h0, pmod_at_ack});
        last_pmod = data[7:0];
        repeat (40) @(posedge clk);
        @(negedge clk);
        check_equal("pmod_o", pmod_o, last_pmod);
        read_word(`KV_REG_PMOD, data);
        check_equal("wb_dat_o", data, {24'h0, last_pmod});

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
verilog/reg_bus_pkg.sv
verilog/periph_pkg.sv
verilog/reg_bus_if.sv
verilog/wb_reg_port.sv
verilog/blink_sequencer.sv
verilog/reg_bus_arbiter.sv
verilog/reg_file.sv
verilog/kv_register_top.sv
tb/tb_kv_register.sv
